/* hw/lsu_defines.svh */
/*
 * Sizing macros for the load/store unit and its data memory.
 * Include this header wherever ID, tag or memory widths are needed.
 */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Memory IDs the LSU can have in flight
`define LSU_NUM_OUTSTANDING 4
`define LSU_ID_WIDTH 2

// Core tag width
`define LSU_TAG_WIDTH 5

// Data memory depth in 32-bit words
`define LSU_MEM_WORDS 64

`endif

/* hw/lsu_pkg.sv */
/*
 * Shared types for the load/store subsystem: access size and atomic
 * opcodes, core and memory channel payloads, and the LSU ID-table entry.
 */

`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  typedef enum logic [3:0] {
    AMO_NONE = 4'h0,
    AMO_SWAP = 4'h1,
    AMO_ADD  = 4'h2,
    AMO_AND  = 4'h3,
    AMO_OR   = 4'h4
  } amo_e;

  // ----------------------------------------
  // Core side
  // ----------------------------------------
  typedef struct packed {
    logic [`LSU_TAG_WIDTH-1:0] tag;
    logic                      write;
    logic                      is_signed;
    logic [31:0]               addr;
    logic [31:0]               data;
    size_e                     size;
    amo_e                      amo;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0]               data;
    logic [`LSU_TAG_WIDTH-1:0] tag;
    logic                      error;
  } lsu_rsp_t;

  // ----------------------------------------
  // Memory side
  // ----------------------------------------
  // Address is always word aligned here
  typedef struct packed {
    logic [31:0]              addr;
    logic                     write;
    amo_e                     amo;
    logic [31:0]              data;
    logic [3:0]               strb;
    logic [`LSU_ID_WIDTH-1:0] id;
  } mem_req_t;

  typedef struct packed {
    logic [31:0]              data;
    logic                     error;
    logic [`LSU_ID_WIDTH-1:0] id;
  } mem_rsp_t;

  // What the LSU needs to finish a request once its ID returns
  typedef struct packed {
    logic                      write;
    logic [`LSU_TAG_WIDTH-1:0] tag;
    logic                      sign_ext;
    logic [1:0]                offset;
    size_e                     size;
  } metadata_t;

endpackage

`default_nettype wire

/* hw/lzc.sv */
/*
 * Priority search for the lowest set bit of a bitmap.
 * The LSU feeds it the free-ID map to pick the next memory ID.
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lzc (
  input  wire  [`LSU_NUM_OUTSTANDING-1:0] in_i,
  output logic [`LSU_ID_WIDTH-1:0]        cnt_o,
  output logic                            empty_o
);

  // Walk from the top down so the lowest set bit wins
  always_comb begin
    cnt_o   = '0;
    empty_o = 1'b1;
    for (int i = `LSU_NUM_OUTSTANDING - 1; i >= 0; i--) begin
      if (in_i[i]) begin
        cnt_o   = `LSU_ID_WIDTH'(i);
        empty_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/lsu.sv */
/*
 * Load/store unit between a core and an out-of-order data memory.
 * Requests get a memory ID from a small table; the table entry is used
 * to shift and extend the load data when that ID comes back.
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu (
  input  wire                  clk_i,
  input  wire                  rst_i,
  // Core request
  input  wire lsu_pkg::lsu_req_t lsu_req_i,
  input  wire                  lsu_qvalid_i,
  output logic                 lsu_qready_o,
  // Core response
  output lsu_pkg::lsu_rsp_t    lsu_rsp_o,
  output logic                 lsu_pvalid_o,
  input  wire                  lsu_pready_i,
  // Memory request
  output lsu_pkg::mem_req_t    mem_req_o,
  output logic                 mem_qvalid_o,
  input  wire                  mem_qready_i,
  // Memory response
  input  wire lsu_pkg::mem_rsp_t mem_rsp_i,
  input  wire                  mem_pvalid_i,
  output logic                 mem_pready_o
);

  import lsu_pkg::*;

  // ----------------------------------------
  // Signals
  // ----------------------------------------
  logic [`LSU_NUM_OUTSTANDING-1:0] id_free_q;
  metadata_t                       metadata_q [`LSU_NUM_OUTSTANDING];
  metadata_t                       req_meta;
  metadata_t                       rsp_meta;

  logic [`LSU_ID_WIDTH-1:0] free_id;
  logic [`LSU_ID_WIDTH-1:0] push_id;
  logic [`LSU_ID_WIDTH-1:0] held_id_q;
  logic                     hold_q;
  logic                     id_full;
  logic                     push;
  logic                     pop;

  logic [3:0]  strb;
  logic [5:0]  store_shamt;
  logic [63:0] store_dbl;
  logic [31:0] shifted_data;
  logic [31:0] ld_result;

  // ----------------------------------------
  // ID table
  // ----------------------------------------
  lzc i_lzc (
    .in_i    ( id_free_q ),
    .cnt_o   ( free_id   ),
    .empty_o ( id_full   )
  );

  // A stalled request keeps the ID it claimed on its first cycle
  assign push_id = hold_q ? held_id_q : free_id;
  assign push    = mem_qvalid_o && !hold_q;
  assign pop     = mem_pvalid_i && mem_pready_o;

  // Atomics answer like loads, so only plain stores count as writes
  assign req_meta = '{
    write:    lsu_req_i.write && (lsu_req_i.amo == AMO_NONE),
    tag:      lsu_req_i.tag,
    sign_ext: lsu_req_i.is_signed,
    offset:   lsu_req_i.addr[1:0],
    size:     lsu_req_i.size
  };

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      id_free_q <= '1;
      hold_q    <= 1'b0;
      held_id_q <= '0;
    end else begin
      if (push) begin
        id_free_q[push_id] <= 1'b0;
      end
      if (pop) begin
        id_free_q[mem_rsp_i.id] <= 1'b1;
      end
      hold_q <= mem_qvalid_o && !mem_qready_i;
      if (mem_qvalid_o && !mem_qready_i) begin
        held_id_q <= push_id;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      metadata_q[push_id] <= req_meta;
    end
  end

  // ----------------------------------------
  // Request path
  // ----------------------------------------
  assign mem_qvalid_o = lsu_qvalid_i && (!id_full || hold_q);
  assign lsu_qready_o = mem_qready_i && (!id_full || hold_q);

  // Byte enables from size and offset
  always_comb begin
    unique case (lsu_req_i.size)
      SIZE_BYTE: strb = 4'b0001 << lsu_req_i.addr[1:0];
      SIZE_HALF: strb = 4'b0011 << lsu_req_i.addr[1:0];
      SIZE_WORD: strb = 4'b1111;
      default:   strb = 4'b0000;
    endcase
  end

  // Rotate left by offset bytes so data lands in its byte lanes
  assign store_shamt = 6'd32 - {1'b0, lsu_req_i.addr[1:0], 3'b000};
  assign store_dbl   = {lsu_req_i.data, lsu_req_i.data} >> store_shamt;

  assign mem_req_o = '{
    addr:  {lsu_req_i.addr[31:2], 2'b00},
    write: lsu_req_i.write,
    amo:   lsu_req_i.amo,
    data:  store_dbl[31:0],
    strb:  strb,
    id:    push_id
  };

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  assign rsp_meta     = metadata_q[mem_rsp_i.id];
  assign shifted_data = mem_rsp_i.data >> {rsp_meta.offset, 3'b000};

  always_comb begin
    unique case (rsp_meta.size)
      SIZE_BYTE: ld_result = {{24{shifted_data[7] & rsp_meta.sign_ext}}, shifted_data[7:0]};
      SIZE_HALF: ld_result = {{16{shifted_data[15] & rsp_meta.sign_ext}}, shifted_data[15:0]};
      default:   ld_result = shifted_data;
    endcase
  end

  assign lsu_rsp_o = '{
    data:  ld_result,
    tag:   rsp_meta.tag,
    error: mem_rsp_i.error
  };

  // Stores retire here without reaching the core
  assign lsu_pvalid_o = mem_pvalid_i && !rsp_meta.write;
  assign mem_pready_o = lsu_pready_i || rsp_meta.write;

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  a_push_id_free : assert property (
    @(posedge clk_i) disable iff (rst_i) push |-> id_free_q[push_id])
    else $error("LSU pushed an ID that is still taken");

  a_rsp_id_taken : assert property (
    @(posedge clk_i) disable iff (rst_i) pop |-> !id_free_q[mem_rsp_i.id])
    else $error("Memory answered with an ID that is not outstanding");

endmodule

`default_nettype wire

/* hw/ooo_data_mem.sv */
/*
 * Word-addressed data memory that runs each access, atomics included,
 * when it is accepted and answers after an address-dependent delay.
 * Responses can therefore return in a different order from requests.
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module ooo_data_mem (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire lsu_pkg::mem_req_t req_i,
  input  wire                  qvalid_i,
  output logic                 qready_o,
  output lsu_pkg::mem_rsp_t    rsp_o,
  output logic                 pvalid_o,
  input  wire                  pready_i
);

  import lsu_pkg::*;

  localparam int NUM_SLOTS = `LSU_NUM_OUTSTANDING;
  localparam int MEM_AW    = $clog2(`LSU_MEM_WORDS);

  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_WAIT,
    SLOT_READY
  } slot_state_e;

  logic [31:0] mem_q        [`LSU_MEM_WORDS];
  slot_state_e slot_state_q [NUM_SLOTS];
  logic [1:0]  slot_cnt_q   [NUM_SLOTS];
  mem_rsp_t    slot_rsp_q   [NUM_SLOTS];

  logic [`LSU_ID_WIDTH-1:0] free_slot;
  logic [`LSU_ID_WIDTH-1:0] ready_slot;
  logic [`LSU_ID_WIDTH-1:0] rsp_slot;
  logic [`LSU_ID_WIDTH-1:0] held_slot_q;
  logic                     any_free;
  logic                     any_ready;
  logic                     hold_q;

  logic              accept;
  logic              retire;
  logic              in_range;
  logic              do_write;
  logic [MEM_AW-1:0] word_idx;
  logic [31:0]       old_word;
  logic [31:0]       new_word;

  // Lowest free slot for allocation, lowest ready slot for answering
  always_comb begin
    free_slot  = '0;
    ready_slot = '0;
    any_free   = 1'b0;
    any_ready  = 1'b0;
    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
      if (slot_state_q[s] == SLOT_FREE) begin
        free_slot = `LSU_ID_WIDTH'(s);
        any_free  = 1'b1;
      end
      if (slot_state_q[s] == SLOT_READY) begin
        ready_slot = `LSU_ID_WIDTH'(s);
        any_ready  = 1'b1;
      end
    end
  end

  // A stalled response stays on the slot it started with
  assign rsp_slot = hold_q ? held_slot_q : ready_slot;
  assign rsp_o    = slot_rsp_q[rsp_slot];
  assign pvalid_o = any_ready;
  assign qready_o = any_free;

  assign accept = qvalid_i && qready_o;
  assign retire = pvalid_o && pready_i;

  // ----------------------------------------
  // Access execution
  // ----------------------------------------
  assign word_idx = req_i.addr[MEM_AW+1:2];
  assign in_range = (req_i.addr[31:2] < `LSU_MEM_WORDS);
  assign old_word = in_range ? mem_q[word_idx] : 32'h0;
  assign do_write = in_range && (req_i.write || (req_i.amo != AMO_NONE));

  always_comb begin
    new_word = old_word;
    unique case (req_i.amo)
      AMO_SWAP: new_word = req_i.data;
      AMO_ADD:  new_word = old_word + req_i.data;
      AMO_AND:  new_word = old_word & req_i.data;
      AMO_OR:   new_word = old_word | req_i.data;
      default: begin
        // Plain store merges only the strobed bytes
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) begin
            new_word[8*b +: 8] = req_i.data[8*b +: 8];
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (accept && do_write) begin
      mem_q[word_idx] <= new_word;
    end
  end

  // ----------------------------------------
  // Response slots
  // ----------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        slot_state_q[s] <= SLOT_FREE;
        slot_cnt_q[s]   <= '0;
      end
      hold_q      <= 1'b0;
      held_slot_q <= '0;
    end else begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        if (slot_state_q[s] == SLOT_WAIT) begin
          if (slot_cnt_q[s] == 2'd1) begin
            slot_state_q[s] <= SLOT_READY;
          end
          slot_cnt_q[s] <= slot_cnt_q[s] - 2'd1;
        end
      end
      if (retire) begin
        slot_state_q[rsp_slot] <= SLOT_FREE;
      end
      // Delay is addr[3:2] + 1 cycles, zero extra goes straight to ready
      if (accept) begin
        slot_state_q[free_slot] <= (req_i.addr[3:2] == 2'd0) ? SLOT_READY : SLOT_WAIT;
        slot_cnt_q[free_slot]   <= req_i.addr[3:2];
      end
      hold_q      <= pvalid_o && !pready_i;
      held_slot_q <= rsp_slot;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_rsp_q[free_slot] <= '{data: old_word, error: !in_range, id: req_i.id};
    end
  end

  a_pvalid_has_slot : assert property (
    @(posedge clk_i) disable iff (rst_i) pvalid_o |-> slot_state_q[rsp_slot] == SLOT_READY)
    else $error("Response valid without a ready slot");

  a_rsp_held : assert property (
    @(posedge clk_i) disable iff (rst_i)
    pvalid_o && !pready_i |=> pvalid_o && $stable(rsp_o))
    else $error("Stalled response changed before it was taken");

endmodule

`default_nettype wire

/* hw/lsu_subsystem.sv */
/*
 * Top level of the load/store subsystem: the LSU in front of the
 * out-of-order data memory. Only the core-side channels are exposed.
 */

`timescale 1ns/1ns
`default_nettype none

module lsu_subsystem (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire lsu_pkg::lsu_req_t lsu_req_i,
  input  wire                    lsu_qvalid_i,
  output logic                   lsu_qready_o,
  output lsu_pkg::lsu_rsp_t      lsu_rsp_o,
  output logic                   lsu_pvalid_o,
  input  wire                    lsu_pready_i
);

  import lsu_pkg::*;

  // LSU to memory channels
  mem_req_t mem_req;
  logic     mem_qvalid;
  logic     mem_qready;
  mem_rsp_t mem_rsp;
  logic     mem_pvalid;
  logic     mem_pready;

  lsu i_lsu (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_qvalid_i ( lsu_qvalid_i ),
    .lsu_qready_o ( lsu_qready_o ),
    .lsu_rsp_o    ( lsu_rsp_o    ),
    .lsu_pvalid_o ( lsu_pvalid_o ),
    .lsu_pready_i ( lsu_pready_i ),
    .mem_req_o    ( mem_req      ),
    .mem_qvalid_o ( mem_qvalid   ),
    .mem_qready_i ( mem_qready   ),
    .mem_rsp_i    ( mem_rsp      ),
    .mem_pvalid_i ( mem_pvalid   ),
    .mem_pready_o ( mem_pready   )
  );

  ooo_data_mem i_ooo_data_mem (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .req_i    ( mem_req    ),
    .qvalid_i ( mem_qvalid ),
    .qready_o ( mem_qready ),
    .rsp_o    ( mem_rsp    ),
    .pvalid_o ( mem_pvalid ),
    .pready_i ( mem_pready )
  );

endmodule

`default_nettype wire

/* verif/tb_lsu_subsystem.sv */
/*
 * Random traffic testbench for the load/store subsystem. A shadow memory
 * mirrors every accepted access and concurrent assertions check each
 * core response. Ends with a stall phase and a drain of all loads.
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_subsystem;

  import lsu_pkg::*;

  localparam int          CLK_PERIOD  = 8;
  localparam int          NUM_TXNS    = 300;
  localparam int          STALL_CHECK = 24;
  localparam int          NUM_TAGS    = 1 << `LSU_TAG_WIDTH;
  localparam logic [31:0] SEED        = 32'hc7001038;

  logic     clk_i;
  logic     rst_i;
  lsu_req_t lsu_req_i;
  logic     lsu_qvalid_i;
  logic     lsu_qready_o;
  lsu_rsp_t lsu_rsp_o;
  logic     lsu_pvalid_o;
  logic     lsu_pready_i;
  logic     rsp_fire;

  // Reference model state
  logic [31:0] shadow_mem [`LSU_MEM_WORDS];
  logic [31:0] exp_data   [NUM_TAGS];
  logic        exp_err    [NUM_TAGS];
  logic        tag_busy   [NUM_TAGS];
  logic        req_taken;
  int          outstanding;
  int          accepted_cnt;
  int          rsp_cnt;
  int          err_cnt;

  // Stimulus state
  logic [31:0] rng;
  int          burst_left;
  int          stall_cycles;

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  lsu_subsystem i_lsu_subsystem (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_qvalid_i ( lsu_qvalid_i ),
    .lsu_qready_o ( lsu_qready_o ),
    .lsu_rsp_o    ( lsu_rsp_o    ),
    .lsu_pvalid_o ( lsu_pvalid_o ),
    .lsu_pready_i ( lsu_pready_i )
  );

  assign rsp_fire = lsu_pvalid_o && lsu_pready_i;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Bytes seen by a load at the given offset and then extended
  function automatic logic [31:0] load_view(input logic [31:0] w, input logic [1:0] off,
                                            input size_e size, input logic sgn);
    logic [31:0] v;
    case (size)
      SIZE_BYTE: begin
        v = {24'h0, w[8*off +: 8]};
        if (sgn && v[7]) v[31:8] = '1;
      end
      SIZE_HALF: begin
        v = {16'h0, w[8*off +: 16]};
        if (sgn && v[15]) v[31:16] = '1;
      end
      default: v = w;
    endcase
    return v;
  endfunction

  // New word after a store or atomic
  function automatic logic [31:0] apply_access(input logic [31:0] old, input lsu_req_t req);
    logic [31:0] w;
    int          nbytes;
    int          off;
    w   = old;
    off = req.addr[1:0];
    case (req.amo)
      AMO_SWAP: w = req.data;
      AMO_ADD:  w = old + req.data;
      AMO_AND:  w = old & req.data;
      AMO_OR:   w = old | req.data;
      default: begin
        if (req.write) begin
          nbytes = (req.size == SIZE_BYTE) ? 1 : (req.size == SIZE_HALF) ? 2 : 4;
          for (int i = 0; i < nbytes; i++) begin
            w[8*(off+i) +: 8] = req.data[8*i +: 8];
          end
        end
      end
    endcase
    return w;
  endfunction

  function automatic logic [`LSU_TAG_WIDTH-1:0] pick_free_tag(input logic [31:0] start);
    logic [`LSU_TAG_WIDTH-1:0] t;
    t = start[`LSU_TAG_WIDTH-1:0];
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (!tag_busy[t]) begin
        return t;
      end
      t = t + 1'b1;
    end
    return t;
  endfunction

  // Response ready in random bursts that are mostly high
  task automatic drive_pready();
    if (burst_left == 0) begin
      rng          = xorshift32(rng);
      burst_left   = 1 + rng[2:0];
      lsu_pready_i = (rng[6:5] != 2'b00);
    end else begin
      burst_left--;
    end
  endtask

  task automatic drive_request(input logic loads_only);
    logic [31:0] r;
    logic [31:0] word;
    logic [2:0]  kind;
    logic [1:0]  off;
    lsu_req_t    req;
    if (!(lsu_qvalid_i && !req_taken)) begin
      rng  = xorshift32(rng);
      r    = rng;
      kind = loads_only ? 3'd0 : r[2:0];
      // 0-2 load, 3-4 store, 5-6 atomic, 7 idle
      if (kind == 3'd7) begin
        lsu_qvalid_i = 1'b0;
      end else begin
        req           = '0;
        word          = (r >> 8) % 70;
        req.tag       = pick_free_tag(r >> 24);
        req.is_signed = r[20];
        if (kind >= 3'd5) begin
          req.size = SIZE_WORD;
          req.amo  = amo_e'(4'd1 + {2'b00, r[23:22]});
          off      = 2'd0;
        end else begin
          req.write = (kind >= 3'd3);
          case (r[17:16])
            2'd0: begin
              req.size = SIZE_BYTE;
              off      = r[19:18];
            end
            2'd1: begin
              req.size = SIZE_HALF;
              off      = (r[19:18] == 2'd3) ? 2'd2 : r[19:18];
            end
            default: begin
              req.size = SIZE_WORD;
              off      = 2'd0;
            end
          endcase
        end
        req.addr     = {word[29:0], off};
        rng          = xorshift32(rng);
        req.data     = rng;
        lsu_req_i    = req;
        lsu_qvalid_i = 1'b1;
      end
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  always @(posedge clk_i) begin : model_update
    logic [31:0] widx;
    logic        in_range;
    logic [31:0] old_word;
    if (rst_i) begin
      for (int w = 0; w < `LSU_MEM_WORDS; w++) shadow_mem[w] = '0;
      for (int t = 0; t < NUM_TAGS; t++) tag_busy[t] = 1'b0;
      req_taken    = 1'b0;
      outstanding  = 0;
      accepted_cnt = 0;
      rsp_cnt      = 0;
    end else begin
      req_taken = lsu_qvalid_i && lsu_qready_o;
      if (rsp_fire) begin
        tag_busy[lsu_rsp_o.tag] = 1'b0;
        outstanding--;
        rsp_cnt++;
      end
      if (req_taken) begin
        accepted_cnt++;
        widx     = {2'b00, lsu_req_i.addr[31:2]};
        in_range = (widx < `LSU_MEM_WORDS);
        old_word = in_range ? shadow_mem[widx] : 32'h0;
        // Loads and atomics expect a response
        if (!lsu_req_i.write || lsu_req_i.amo != AMO_NONE) begin
          exp_data[lsu_req_i.tag] = load_view(old_word, lsu_req_i.addr[1:0],
                                              lsu_req_i.size, lsu_req_i.is_signed);
          exp_err[lsu_req_i.tag]  = !in_range;
          tag_busy[lsu_req_i.tag] = 1'b1;
          outstanding++;
        end
        if (in_range) shadow_mem[widx] = apply_access(old_word, lsu_req_i);
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_rsp_tag : assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_fire |-> tag_busy[lsu_rsp_o.tag])
    else begin
      err_cnt++;
      $display("Response at %0t carries tag %0d, which has no outstanding load or atomic",
               $time, $sampled(lsu_rsp_o.tag));
    end

  a_rsp_data : assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_fire && tag_busy[lsu_rsp_o.tag] |-> lsu_rsp_o.data == exp_data[lsu_rsp_o.tag])
    else begin
      err_cnt++;
      $display("[FAIL] %0t lsu_rsp_o.data got %h expected %h", $time,
               $sampled(lsu_rsp_o.data), $sampled(exp_data[lsu_rsp_o.tag]));
    end

  a_rsp_error : assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_fire && tag_busy[lsu_rsp_o.tag] |-> lsu_rsp_o.error == exp_err[lsu_rsp_o.tag])
    else begin
      err_cnt++;
      $display("[FAIL] %0t lsu_rsp_o.error got %b expected %b", $time,
               $sampled(lsu_rsp_o.error), $sampled(exp_err[lsu_rsp_o.tag]));
    end

  a_stall_blocks : assert property (@(posedge clk_i) disable iff (rst_i)
    stall_cycles == STALL_CHECK |-> !lsu_qready_o)
    else begin
      err_cnt++;
      $display("[FAIL] %0t lsu_qready_o got %b expected 0 under back-pressure", $time,
               $sampled(lsu_qready_o));
    end

  a_pvalid_in_reset : assert property (@(posedge clk_i) rst_i |-> !lsu_pvalid_o)
    else begin
      err_cnt++;
      $display("[FAIL] %0t lsu_pvalid_o got 1 expected 0 during reset", $time);
    end

  a_pvalid_after_reset : assert property (@(posedge clk_i) $fell(rst_i) |-> !lsu_pvalid_o)
    else begin
      err_cnt++;
      $display("[FAIL] %0t lsu_pvalid_o got 1 expected 0 after reset", $time);
    end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    rst_i        = 1'b1;
    lsu_req_i    = '0;
    lsu_qvalid_i = 1'b0;
    lsu_pready_i = 1'b0;
    err_cnt      = 0;
    rng          = SEED;
    burst_left   = 0;
    stall_cycles = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    while (accepted_cnt < NUM_TXNS) begin
      @(negedge clk_i);
      drive_pready();
      drive_request(1'b0);
    end

    // Loads only while responses are held off
    lsu_pready_i = 1'b0;
    repeat (STALL_CHECK + 4) begin
      @(negedge clk_i);
      stall_cycles++;
      drive_request(1'b1);
    end
    stall_cycles = 0;

    // Drain everything still in flight
    lsu_pready_i = 1'b1;
    for (int c = 0; c < 200 && (lsu_qvalid_i || outstanding != 0); c++) begin
      @(negedge clk_i);
      if (req_taken) lsu_qvalid_i = 1'b0;
    end
    assert (outstanding == 0 && !lsu_qvalid_i)
      else begin
        err_cnt++;
        $display("Drain did not finish, %0d loads still unanswered", outstanding);
      end

    @(negedge clk_i);
    $display("Summary: %0d requests, %0d responses, %0d errors",
             accepted_cnt, rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(NUM_TXNS * 40 * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish in time");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/lsu_pkg.sv
hw/lzc.sv
hw/lsu.sv
hw/ooo_data_mem.sv
hw/lsu_subsystem.sv
verif/tb_lsu_subsystem.sv

/* Bender.yml */
package:
  name: lsu_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/lzc.sv
      - hw/lsu.sv
      - hw/ooo_data_mem.sv
      - hw/lsu_subsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_lsu_subsystem.sv
